// File: burstControl.sv
// Fixed priority fill > CLUT > TEX; relies on the memory acking exactly memCnt_o+1 cycles
`timescale 1ns/1ps

module burstControl
	import memBusPkg::*;
	import gpuCachePkg::*;
(
	input  logic        gpuClk,
	input  logic        resetX,
	// Fill command
	input  logic        fillReq_i,
	input  clutLineAdrT fillAdr_i,
	input  fillColorT   fillColor_i,
	// Merged cache requests
	input  logic        clutReq_i,
	input  clutLineAdrT clutAdr_i,
	input  logic        texReq_i,
	input  texLineAdrT  texAdr_i,
	// Memory bus
	input  logic        memAck_i,
	output logic        memReq_o,
	output logic        memWrite_o,
	output memAdrT      memAdr_o,
	output beatCntT     memCnt_o,
	output memSelT      memSel_o,
	output memDataT     memDatW_o,
	// Grants to the cache side selectors
	output logic        clutGrant_o,
	output logic        texGrant_o,
	// Beat info for the read data path
	output burstKindT   burstKind_o,
	output logic        beatStrobe_o,
	output beatCntT     beatIdx_o,
	output logic        busy_o
);

	`include "gpuMem_config.svh"

	// Byte shift from block address to base address
	localparam int CLUT_SHIFT = $clog2(`CLUT_BEATS * (`MEM_DATA_W / 8));
	localparam int TEX_SHIFT  = $clog2(`TEX_BEATS * (`MEM_DATA_W / 8));

	// Burst in flight
	burstKindT kindQ;
	// Kind granted this cycle, IDLE if none
	burstKindT pick;
	// Beat counter and burst length
	beatCntT   beatQ;
	beatCntT   cntQ;
	// Latched block base and fill colour
	memAdrT    baseQ;
	fillColorT colorQ;
	logic      lastBeat;

	// -----------------------------------------------------------------------
	// Grant
	// -----------------------------------------------------------------------

	always_comb begin
		pick = IDLE;
		// Never start while the memory still acks a previous burst
		if (kindQ == IDLE && !memAck_i) begin
			if (fillReq_i) begin
				pick = FILL;
			end else if (clutReq_i) begin
				pick = CLUT;
			end else if (texReq_i) begin
				pick = TEX;
			end
		end
	end

	assign clutGrant_o = (pick == CLUT);
	assign texGrant_o  = (pick == TEX);

	// -----------------------------------------------------------------------
	// State and beat counter
	// -----------------------------------------------------------------------

	assign lastBeat = (beatQ == cntQ);

	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			kindQ <= IDLE;
			beatQ <= '0;
		end else if (pick != IDLE) begin
			kindQ <= pick;
			beatQ <= '0;
		end else if (kindQ != IDLE && memAck_i) begin
			beatQ <= beatCntT'(beatQ + 1'b1);
			// Ack drops right after the last beat, back to idle with it
			if (lastBeat) begin
				kindQ <= IDLE;
			end
		end
	end

	// Burst parameters, latched at grant
	always_ff @(posedge gpuClk) begin
		case (pick)
			FILL: begin
				cntQ   <= beatCntT'(`FILL_BEATS - 1);
				baseQ  <= memAdrT'(fillAdr_i) << CLUT_SHIFT;
				colorQ <= fillColor_i;
			end
			CLUT: begin
				cntQ  <= beatCntT'(`CLUT_BEATS - 1);
				baseQ <= memAdrT'(clutAdr_i) << CLUT_SHIFT;
			end
			TEX: begin
				cntQ  <= beatCntT'(`TEX_BEATS - 1);
				baseQ <= memAdrT'(texAdr_i) << TEX_SHIFT;
			end
			default: begin
				// Hold
			end
		endcase
	end

	// -----------------------------------------------------------------------
	// Bus outputs
	// -----------------------------------------------------------------------

	// Request up the cycle after grant, down the cycle after last ack
	assign memReq_o   = (kindQ != IDLE);
	assign busy_o     = (kindQ != IDLE);
	assign memWrite_o = (kindQ == FILL);
	assign memCnt_o   = cntQ;

	// Word address steps by one beat per ack
	assign memAdr_o = baseQ + (memAdrT'(beatQ) << 2);

	// Two pixels per word, bit 15 of each left clear
	assign memDatW_o = {1'b0, colorQ, 1'b0, colorQ};
	// Whole word always
	assign memSel_o  = '1;

	// Beat info to the read side
	assign burstKind_o  = kindQ;
	assign beatStrobe_o = memAck_i & (kindQ != IDLE);
	assign beatIdx_o    = beatQ;

endmodule

// File: gpuCachePkg.sv
// GPU-side types; TEX data is two bus beats wide and CLUT index covers one 8-beat block
`include "gpuMem_config.svh"

package gpuCachePkg;

	// -----------------------------------------------------------------------
	// Cache and fill types
	// -----------------------------------------------------------------------

	// 8-byte TEX line, byte address is this shifted by 3
	typedef logic [`TEX_LINE_W-1:0] texLineAdrT;

	// 32-byte block, shared by CLUT refill and fill
	typedef logic [`CLUT_LINE_W-1:0] clutLineAdrT;

	// Fill colour, 15-bit RGB
	typedef logic [`FILL_COLOR_W-1:0] fillColorT;

	// Packed TEX line, second beat on top
	typedef logic [2*`MEM_DATA_W-1:0] texDataT;

	// Word index inside a CLUT block
	typedef logic [`BURST_CNT_W-1:0] clutIdxT;

	// Burst in flight, IDLE when the bus is free
	typedef enum logic [1:0] {
		IDLE,
		FILL,
		CLUT,
		TEX
	} burstKindT;

endpackage

// File: gpuMem_config.svh
// Widths assume a 1 MB byte-addressed VRAM on a 32-bit burst bus with at most 8 beats
`ifndef GPU_MEM_CONFIG_SVH
`define GPU_MEM_CONFIG_SVH

// ---------------------------------------------------------------------------
// Memory bus
// ---------------------------------------------------------------------------

// Byte address into VRAM
`define MEM_ADR_W 20
// One beat on the bus
`define MEM_DATA_W 32
// Beat count, sent as beats minus one
`define BURST_CNT_W 3

// ---------------------------------------------------------------------------
// GPU side
// ---------------------------------------------------------------------------

// Address of an 8-byte TEX line
`define TEX_LINE_W 17
// Address of a 32-byte CLUT or fill block
`define CLUT_LINE_W 15
// 15-bit colour, doubled on the bus
`define FILL_COLOR_W 15

// Beats per burst kind
`define TEX_BEATS 2
`define CLUT_BEATS 8
`define FILL_BEATS 8

`endif

// File: memArbiter.sv
// GPU memory arbiter top; one burst at a time, requesters hold their level until done
`timescale 1ns/1ps

module memArbiter
	import memBusPkg::*;
	import gpuCachePkg::*;
(
	input  logic        gpuClk,
	input  logic        resetX,
	// Fill command
	input  logic        fillReq_i,
	input  clutLineAdrT fillAdr_i,
	input  fillColorT   fillColor_i,
	// TEX cache misses
	input  logic        texReqL_i,
	input  texLineAdrT  texAdrL_i,
	input  logic        texReqR_i,
	input  texLineAdrT  texAdrR_i,
	output logic        texDoneL_o,
	output logic        texDoneR_o,
	// CLUT cache misses
	input  logic        clutReqL_i,
	input  clutLineAdrT clutAdrL_i,
	input  logic        clutReqR_i,
	input  clutLineAdrT clutAdrR_i,
	output logic        clutDoneL_o,
	output logic        clutDoneR_o,
	// TEX cache write
	output logic        texWrite_o,
	output texDataT     texData_o,
	output texLineAdrT  texWriteAdr_o,
	// CLUT cache write
	output logic        clutWrite_o,
	output clutIdxT     clutIndex_o,
	output memDataT     clutData_o,
	output logic        busy_o,
	// Memory bus
	output logic        memReq_o,
	output logic        memWrite_o,
	output memAdrT      memAdr_o,
	output beatCntT     memCnt_o,
	output memSelT      memSel_o,
	output memDataT     memDatW_o,
	input  logic        memAck_i,
	input  memDataT     memDatR_i
);

	// -----------------------------------------------------------------------
	// Internal wires
	// -----------------------------------------------------------------------

	// Merged cache requests
	logic        texReq;
	texLineAdrT  texAdr;
	logic        clutReq;
	clutLineAdrT clutAdr;
	// Grants and completions
	logic        texGrant;
	logic        clutGrant;
	logic        texDone;
	logic        clutDone;
	// Beat info
	burstKindT   burstKind;
	logic        beatStrobe;
	beatCntT     beatIdx;

	// L over R per cache
	missSelect #(.lineAdrT(texLineAdrT)) texSel (
		.gpuClk  (gpuClk),
		.resetX  (resetX),
		.reqL_i  (texReqL_i),
		.adrL_i  (texAdrL_i),
		.reqR_i  (texReqR_i),
		.adrR_i  (texAdrR_i),
		.grant_i (texGrant),
		.done_i  (texDone),
		.req_o   (texReq),
		.adr_o   (texAdr),
		.doneL_o (texDoneL_o),
		.doneR_o (texDoneR_o)
	);

	missSelect #(.lineAdrT(clutLineAdrT)) clutSel (
		.gpuClk  (gpuClk),
		.resetX  (resetX),
		.reqL_i  (clutReqL_i),
		.adrL_i  (clutAdrL_i),
		.reqR_i  (clutReqR_i),
		.adrR_i  (clutAdrR_i),
		.grant_i (clutGrant),
		.done_i  (clutDone),
		.req_o   (clutReq),
		.adr_o   (clutAdr),
		.doneL_o (clutDoneL_o),
		.doneR_o (clutDoneR_o)
	);

	// Bus FSM
	burstControl burstCtl (
		.gpuClk       (gpuClk),
		.resetX       (resetX),
		.fillReq_i    (fillReq_i),
		.fillAdr_i    (fillAdr_i),
		.fillColor_i  (fillColor_i),
		.clutReq_i    (clutReq),
		.clutAdr_i    (clutAdr),
		.texReq_i     (texReq),
		.texAdr_i     (texAdr),
		.memAck_i     (memAck_i),
		.memReq_o     (memReq_o),
		.memWrite_o   (memWrite_o),
		.memAdr_o     (memAdr_o),
		.memCnt_o     (memCnt_o),
		.memSel_o     (memSel_o),
		.memDatW_o    (memDatW_o),
		.clutGrant_o  (clutGrant),
		.texGrant_o   (texGrant),
		.burstKind_o  (burstKind),
		.beatStrobe_o (beatStrobe),
		.beatIdx_o    (beatIdx),
		.busy_o       (busy_o)
	);

	// Read beats into cache writes
	refillDataPath refillPath (
		.gpuClk        (gpuClk),
		.resetX        (resetX),
		.burstKind_i   (burstKind),
		.beatStrobe_i  (beatStrobe),
		.beatIdx_i     (beatIdx),
		.memDatR_i     (memDatR_i),
		.texLine_i     (texAdr),
		.texWrite_o    (texWrite_o),
		.texData_o     (texData_o),
		.texWriteAdr_o (texWriteAdr_o),
		.clutWrite_o   (clutWrite_o),
		.clutIndex_o   (clutIndex_o),
		.clutData_o    (clutData_o),
		.texDone_o     (texDone),
		.clutDone_o    (clutDone)
	);

endmodule

// File: memBusPkg.sv
// Bus-side types only; the beat count field limits a burst to 8 beats
`include "gpuMem_config.svh"

package memBusPkg;

	// -----------------------------------------------------------------------
	// Memory bus types
	// -----------------------------------------------------------------------

	// Byte address, beats step by 4
	typedef logic [`MEM_ADR_W-1:0] memAdrT;

	// One bus beat, read or write
	typedef logic [`MEM_DATA_W-1:0] memDataT;

	// Beats minus one on memCnt_o
	// Also used as the running beat index
	typedef logic [`BURST_CNT_W-1:0] beatCntT;

	// One select bit per byte lane
	typedef logic [`MEM_DATA_W/8-1:0] memSelT;

endpackage

// File: missSelect.sv
// Requesters must hold request and address until their done pulse, or the served address moves
`timescale 1ns/1ps

module missSelect #(
	parameter type lineAdrT = logic
) (
	input  logic    gpuClk,
	input  logic    resetX,
	// Left requester
	input  logic    reqL_i,
	input  lineAdrT adrL_i,
	// Right requester
	input  logic    reqR_i,
	input  lineAdrT adrR_i,
	// From the arbiter
	input  logic    grant_i,
	input  logic    done_i,
	// Merged request to the arbiter
	output logic    req_o,
	output lineAdrT adr_o,
	// Completion, served side only
	output logic    doneL_o,
	output logic    doneR_o
);

	// Served side, high for R
	logic servedRQ;
	// Burst for this cache in flight
	logic activeQ;

	// -----------------------------------------------------------------------
	// Side tracking
	// -----------------------------------------------------------------------

	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			servedRQ <= 1'b0;
			activeQ  <= 1'b0;
		end else if (grant_i) begin
			// L wins, so R is served only when L is quiet
			servedRQ <= ~reqL_i;
			activeQ  <= 1'b1;
		end else if (done_i) begin
			activeQ  <= 1'b0;
		end
	end

	// -----------------------------------------------------------------------
	// Merge
	// -----------------------------------------------------------------------

	assign req_o = reqL_i | reqR_i;

	always_comb begin
		if (activeQ) begin
			// Hold the served line even if L shows up mid-burst
			adr_o = servedRQ ? adrR_i : adrL_i;
		end else begin
			adr_o = reqL_i ? adrL_i : adrR_i;
		end
	end

	// Completion goes back to whoever was granted
	assign doneL_o = done_i & ~servedRQ;
	assign doneR_o = done_i & servedRQ;

endmodule

// File: refillDataPath.sv
// TEX line is assumed two beats and CLUT block a full index range; beats arrive in order from 0
`timescale 1ns/1ps

module refillDataPath
	import memBusPkg::*;
	import gpuCachePkg::*;
(
	input  logic       gpuClk,
	input  logic       resetX,
	// Beat info from the burst FSM
	input  burstKindT  burstKind_i,
	input  logic       beatStrobe_i,
	input  beatCntT    beatIdx_i,
	input  memDataT    memDatR_i,
	// Served TEX line
	input  texLineAdrT texLine_i,
	// TEX cache write
	output logic       texWrite_o,
	output texDataT    texData_o,
	output texLineAdrT texWriteAdr_o,
	// CLUT cache write
	output logic       clutWrite_o,
	output clutIdxT    clutIndex_o,
	output memDataT    clutData_o,
	// Completions before side steering
	output logic       texDone_o,
	output logic       clutDone_o
);

	// Last beat index of each read kind
	localparam beatCntT TEX_LAST  = beatCntT'($bits(texDataT) / $bits(memDataT) - 1);
	localparam clutIdxT CLUT_LAST = '1;

	logic       texBeat;
	logic       clutBeat;
	// Lower half of the TEX line
	memDataT    texLowQ;
	texLineAdrT texLineQ;
	// Lower half held and waiting
	logic       texHalfQ;

	assign texBeat  = beatStrobe_i & (burstKind_i == TEX);
	assign clutBeat = beatStrobe_i & (burstKind_i == CLUT);

	// -----------------------------------------------------------------------
	// TEX packing
	// -----------------------------------------------------------------------

	// First beat kept with the line it belongs to
	always_ff @(posedge gpuClk) begin
		if (texBeat && beatIdx_i == '0) begin
			texLowQ  <= memDatR_i;
			texLineQ <= texLine_i;
		end
	end

	always_ff @(posedge gpuClk) begin
		if (resetX) begin
			texHalfQ <= 1'b0;
		end else if (texBeat) begin
			texHalfQ <= (beatIdx_i == '0);
		end
	end

	// Write on the second beat, straight from the bus
	assign texWrite_o    = texBeat & texHalfQ & (beatIdx_i == TEX_LAST);
	assign texData_o     = {memDatR_i, texLowQ};
	assign texWriteAdr_o = texLineQ;
	assign texDone_o     = texWrite_o;

	// -----------------------------------------------------------------------
	// CLUT forwarding
	// -----------------------------------------------------------------------

	// One cache word per ack
	assign clutWrite_o = clutBeat;
	assign clutIndex_o = clutIdxT'(beatIdx_i);
	assign clutData_o  = memDatR_i;
	// Done rides along with the eighth write
	assign clutDone_o  = clutBeat & (clutIdxT'(beatIdx_i) == CLUT_LAST);

endmodule

// File: runSim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
	-f vlog.f --top-module tbMemArbiter -o simMemArbiter

# A failing run exits nonzero, the log decides either way
./obj_dir/simMemArbiter > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "TEST PASS" "$LOG"; then
	echo "Simulation passed"
else
	echo "Simulation failed, see $LOG"
	exit 1
fi

// File: tbMemArbiter.sv
// Model memory spans 1 KB, so table addresses must stay inside it; ack delay is 1 to 4 cycles
`timescale 1ns/1ps

module tbMemArbiter
	import memBusPkg::*;
	import gpuCachePkg::*;
();

	localparam int NUM_TESTS = 7;
	// Cycles allowed for one table entry
	localparam int ENTRY_TIMEOUT = 600;

	// One table row with side bits clutL, clutR, texL, texR from bit 0
	typedef struct {
		string       name;
		logic        fill;
		logic [3:0]  sides;
		clutLineAdrT fillAdr;
		fillColorT   color;
		clutLineAdrT clutAdrL;
		clutLineAdrT clutAdrR;
		texLineAdrT  texAdrL;
		texLineAdrT  texAdrR;
	} testT;

	typedef enum int {
		BUS_IDLE,
		BUS_WAIT,
		BUS_ACK
	} busStateT;

	// DUT ports
	logic        gpuClk;
	logic        resetX;
	logic        fillReq_i;
	clutLineAdrT fillAdr_i;
	fillColorT   fillColor_i;
	logic        texReqL_i;
	texLineAdrT  texAdrL_i;
	logic        texReqR_i;
	texLineAdrT  texAdrR_i;
	logic        texDoneL_o;
	logic        texDoneR_o;
	logic        clutReqL_i;
	clutLineAdrT clutAdrL_i;
	logic        clutReqR_i;
	clutLineAdrT clutAdrR_i;
	logic        clutDoneL_o;
	logic        clutDoneR_o;
	logic        texWrite_o;
	texDataT     texData_o;
	texLineAdrT  texWriteAdr_o;
	logic        clutWrite_o;
	clutIdxT     clutIndex_o;
	memDataT     clutData_o;
	logic        busy_o;
	logic        memReq_o;
	logic        memWrite_o;
	memAdrT      memAdr_o;
	beatCntT     memCnt_o;
	memSelT      memSel_o;
	memDataT     memDatW_o;
	logic        memAck_i;
	memDataT     memDatR_i;

	// Model memory with one word per bus beat
	memDataT    mem [0:255];
	testT       tests [NUM_TESTS];
	testT       curTest;
	string      curName;
	// Completions still owed in this entry
	logic [3:0] pending;
	logic       firstSeen;
	logic       firstWrite;
	// CLUT beats since the last completion
	clutIdxT    clutIdxQ [$];
	memDataT    clutDatQ [$];

	memArbiter uut (.*);

	always begin
		gpuClk = 1'b0;
		#10;
		gpuClk = 1'b1;
		#10;
	end

	// ------------------------------------------------------------------------
	// Address helpers
	// ------------------------------------------------------------------------

	// 32-byte block
	function automatic memAdrT clutBase(input clutLineAdrT adr);
		return memAdrT'(adr) << 5;
	endfunction

	// 8-byte line
	function automatic memAdrT texBase(input texLineAdrT line);
		return memAdrT'(line) << 3;
	endfunction

	// Word k of a burst wrapped into the model
	function automatic logic [7:0] wordAt(input memAdrT base, input int k);
		return 8'(base[9:2] + 8'(k));
	endfunction

	// ------------------------------------------------------------------------
	// Failure and compare tasks
	// ------------------------------------------------------------------------

	task automatic reportMismatch(input string name, input string expS, input string actS);
		$display("TEST FAIL");
		$display("[ERROR] %s expected %s actual %s", name, expS, actS);
		$fatal(1, "value mismatch");
	endtask

	task automatic abortRun(input string why);
		$display("TEST FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			reportMismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
		end
	endtask

	task automatic checkMemWord(input string name, input memDataT exp, input memDataT act);
		if (act !== exp) begin
			reportMismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
		end
	endtask

	task automatic checkMemSel(input string name, input memSelT exp, input memSelT act);
		if (act !== exp) begin
			reportMismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
		end
	endtask

	task automatic checkBeatCnt(input string name, input beatCntT exp, input beatCntT act);
		if (act !== exp) begin
			reportMismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
		end
	endtask

	task automatic checkMemAdr(input string name, input memAdrT exp, input memAdrT act);
		if (act !== exp) begin
			reportMismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
		end
	endtask

	task automatic checkTex(input string name, input texDataT exp, input texDataT act);
		if (act !== exp) begin
			reportMismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
		end
	endtask

	task automatic checkTexLine(input string name, input texLineAdrT exp,
			input texLineAdrT act);
		if (act !== exp) begin
			reportMismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
		end
	endtask

	task automatic checkClut(input string name, input memDataT expDat, input clutIdxT expIdx,
			input memDataT actDat, input clutIdxT actIdx);
		if (actIdx !== expIdx) begin
			reportMismatch({name, " index"}, $sformatf("%0d", expIdx), $sformatf("%0d", actIdx));
		end else if (actDat !== expDat) begin
			reportMismatch({name, " data"}, $sformatf("%h", expDat), $sformatf("%h", actDat));
		end
	endtask

	// ------------------------------------------------------------------------
	// Bus memory model
	// ------------------------------------------------------------------------

	initial begin
		busStateT mState;
		int       mDelay;
		beatCntT  mBeat;
		beatCntT  mLast;
		memAdrT   mBase;
		void'($urandom(26915));
		for (int i = 0; i < 256; i++) begin
			mem[i] = $urandom;
		end
		memAck_i = 1'b0;
		memDatR_i = '0;
		mState = BUS_IDLE;
		mDelay = 0;
		mBeat = '0;
		mLast = '0;
		mBase = '0;
		forever begin
			@(posedge gpuClk);
			if (resetX) begin
				memAck_i <= 1'b0;
				mState = BUS_IDLE;
			end else begin
				case (mState)
					BUS_IDLE: begin
						// Beat 0 address is the block base
						if (memReq_o) begin
							mBase = memAdr_o;
							mLast = memCnt_o;
							mBeat = '0;
							mDelay = int'($urandom_range(4, 1));
							mState = BUS_WAIT;
						end
					end
					BUS_WAIT: begin
						if (mDelay <= 1) begin
							memAck_i <= 1'b1;
							memDatR_i <= mem[wordAt(mBase, 0)];
							mState = BUS_ACK;
						end else begin
							mDelay--;
						end
					end
					default: begin
						// End of ack cycle for beat mBeat
						checkMemAdr({curName, " beat address"},
							mBase + (memAdrT'(mBeat) << 2), memAdr_o);
						if (memWrite_o) begin
							checkMemSel({curName, " byte select"}, '1, memSel_o);
							mem[wordAt(memAdr_o, 0)] <= memDatW_o;
						end
						if (mBeat == mLast) begin
							memAck_i <= 1'b0;
							mState = BUS_IDLE;
						end else begin
							mBeat++;
							memDatR_i <= mem[wordAt(mBase, int'(mBeat))];
						end
					end
				endcase
			end
		end
	end

	// ------------------------------------------------------------------------
	// Per-cycle sampling
	// ------------------------------------------------------------------------

	task automatic verifyClut(input clutLineAdrT adr);
		// Eight beats on the bus
		checkBeatCnt({curName, " CLUT beat count"}, beatCntT'(7), memCnt_o);
		if (clutDatQ.size() != 8) begin
			abortRun($sformatf("%s got %0d CLUT beats instead of 8", curName, clutDatQ.size()));
		end
		for (int k = 0; k < 8; k++) begin
			checkClut($sformatf("%s beat %0d", curName, k), mem[wordAt(clutBase(adr), k)],
				clutIdxT'(k), clutDatQ[k], clutIdxQ[k]);
		end
		clutDatQ.delete();
		clutIdxQ.delete();
	endtask

	// Second beat on top
	task automatic verifyTex(input texLineAdrT line);
		checkBit({curName, " texWrite_o"}, 1'b1, texWrite_o);
		// Two beats on the bus
		checkBeatCnt({curName, " tex beat count"}, beatCntT'(1), memCnt_o);
		checkTex({curName, " tex data"},
			{mem[wordAt(texBase(line), 1)], mem[wordAt(texBase(line), 0)]}, texData_o);
		checkTexLine({curName, " tex line"}, line, texWriteAdr_o);
	endtask

	// Requester lets go at its own completion
	task automatic dropRequest(input int side);
		case (side)
			0: clutReqL_i <= 1'b0;
			1: clutReqR_i <= 1'b0;
			2: texReqL_i <= 1'b0;
			default: texReqR_i <= 1'b0;
		endcase
	endtask

	task automatic sampleCycle();
		logic [3:0] doneNow;
		int         side;
		@(posedge gpuClk);
		doneNow = {texDoneR_o, texDoneL_o, clutDoneR_o, clutDoneL_o};
		side = -1;
		if (memReq_o && !firstSeen) begin
			firstSeen = 1'b1;
			firstWrite = memWrite_o;
		end
		// GPU drops the fill once it sees busy
		if (fillReq_i && busy_o) begin
			fillReq_i <= 1'b0;
		end
		if (clutWrite_o) begin
			clutIdxQ.push_back(clutIndex_o);
			clutDatQ.push_back(clutData_o);
		end
		if (texWrite_o && doneNow[3:2] == 2'b00) begin
			abortRun($sformatf("%s saw a TEX write with no completion pulse", curName));
		end
		if (doneNow != 4'b0000) begin
			// Lowest owed side is next by priority
			for (int i = 3; i >= 0; i--) begin
				if (pending[i]) begin
					side = i;
				end
			end
			if (side < 0) begin
				abortRun($sformatf("%s saw a completion pulse with nothing owed", curName));
			end
			for (int i = 0; i < 4; i++) begin
				checkBit($sformatf("%s done side %0d", curName, i), (side == i), doneNow[i]);
			end
			if (side < 2) begin
				verifyClut(side == 0 ? curTest.clutAdrL : curTest.clutAdrR);
			end else begin
				verifyTex(side == 2 ? curTest.texAdrL : curTest.texAdrR);
			end
			pending[side] = 1'b0;
			dropRequest(side);
		end
	endtask

	// ------------------------------------------------------------------------
	// Table entry
	// ------------------------------------------------------------------------

	task automatic runEntry(input int t);
		int waitCnt;
		curTest = tests[t];
		curName = curTest.name;
		pending = curTest.sides;
		firstSeen = 1'b0;
		firstWrite = 1'b0;
		waitCnt = 0;
		@(posedge gpuClk);
		fillReq_i <= curTest.fill;
		fillAdr_i <= curTest.fillAdr;
		fillColor_i <= curTest.color;
		clutReqL_i <= curTest.sides[0];
		clutReqR_i <= curTest.sides[1];
		texReqL_i <= curTest.sides[2];
		texReqR_i <= curTest.sides[3];
		clutAdrL_i <= curTest.clutAdrL;
		clutAdrR_i <= curTest.clutAdrR;
		texAdrL_i <= curTest.texAdrL;
		texAdrR_i <= curTest.texAdrR;
		do begin
			sampleCycle();
			waitCnt++;
			if (waitCnt > ENTRY_TIMEOUT) begin
				abortRun($sformatf("timeout waiting for %s completions and busy_o to fall",
					curName));
			end
		end while (pending != 4'b0000 || fillReq_i || busy_o);
		if (clutDatQ.size() != 0) begin
			abortRun($sformatf("%s left CLUT writes without a completion pulse", curName));
		end
		if (curTest.fill) begin
			// Fill outranks everything else
			checkBit({curName, " fill served first"}, 1'b1, firstWrite);
			for (int k = 0; k < 8; k++) begin
				checkMemWord($sformatf("%s fill word %0d", curName, k),
					{1'b0, curTest.color, 1'b0, curTest.color},
					mem[wordAt(clutBase(curTest.fillAdr), k)]);
			end
		end
	endtask

	// Nothing moving on the bus or toward the caches
	task automatic checkQuiet(input string name);
		checkBit({name, " memReq_o"}, 1'b0, memReq_o);
		checkBit({name, " memWrite_o"}, 1'b0, memWrite_o);
		checkBit({name, " busy_o"}, 1'b0, busy_o);
		checkBit({name, " texWrite_o"}, 1'b0, texWrite_o);
		checkBit({name, " clutWrite_o"}, 1'b0, clutWrite_o);
		checkBit({name, " completions"}, 1'b0,
			texDoneL_o | texDoneR_o | clutDoneL_o | clutDoneR_o);
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------

	initial begin
		resetX = 1'b1;
		fillReq_i = 1'b0;
		fillAdr_i = '0;
		fillColor_i = '0;
		texReqL_i = 1'b0;
		texAdrL_i = '0;
		texReqR_i = 1'b0;
		texAdrR_i = '0;
		clutReqL_i = 1'b0;
		clutAdrL_i = '0;
		clutReqR_i = 1'b0;
		clutAdrR_i = '0;
		// Name, fill, sides, fill block, colour, CLUT L, CLUT R, TEX L, TEX R
		tests[0] = '{"fill", 1'b1, 4'b0000, 15'd5, 15'h2a5c, 15'd0, 15'd0, 17'd0, 17'd0};
		tests[1] = '{"clutL", 1'b0, 4'b0001, 15'd0, 15'd0, 15'd3, 15'd0, 17'd0, 17'd0};
		tests[2] = '{"clutR", 1'b0, 4'b0010, 15'd0, 15'd0, 15'd0, 15'd7, 17'd0, 17'd0};
		tests[3] = '{"texL", 1'b0, 4'b0100, 15'd0, 15'd0, 15'd0, 15'd0, 17'h21, 17'd0};
		tests[4] = '{"texR", 1'b0, 4'b1000, 15'd0, 15'd0, 15'd0, 15'd0, 17'd0, 17'h4a};
		tests[5] = '{"allCaches", 1'b0, 4'b1111, 15'd0, 15'd0, 15'd9, 15'd10, 17'h30, 17'h31};
		// CLUT reads back the block the fill just wrote
		tests[6] = '{"fillFirst", 1'b1, 4'b0001, 15'd14, 15'h0f0f, 15'd14, 15'd0, 17'd0, 17'd0};
		repeat (5) @(posedge gpuClk);
		resetX <= 1'b0;
		@(posedge gpuClk);
		checkQuiet("reset");
		for (int t = 0; t < NUM_TESTS; t++) begin
			runEntry(t);
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+.
memBusPkg.sv
gpuCachePkg.sv
missSelect.sv
burstControl.sv
refillDataPath.sv
memArbiter.sv
tbMemArbiter.sv
